// File: spec_video.f
common/spec_video_pkg.sv
verilog/raster_timer.sv
video/screen_scaler.sv
video/video_ram.sv
video/pixel_shifter.sv
verilog/spec_video.sv
test/tb_spec_video.sv

// File: test/tb_spec_video.sv
// video path testbench with random vram fill, reference model, compare tasks and frame counters
`timescale 1ns/100ps

module tb_spec_video;
    import spec_video_pkg::*;

    logic        clk_pixel;
    logic        i_reset;
    vram_wr_t    i_vram_wr;
    rgb_out_t    o_rgb;

    vram_word_t  model [0:VRAM_DEPTH-1];    // copy of everything written
    int          check_errors;
    int          timeout_errors;
    int          line_count;                 // lines with any de
    int          border_count;               // de high with rgb dark and p set
    int          dark_count;                 // de high with rgb dark and p clear
    int          blank_bad;                  // anything lit outside de
    int          lit_count [1:7];            // indexed by {r, g, b}

    spec_video uut (
        .i_clk_pixel (clk_pixel),
        .i_reset     (i_reset),
        .i_vram_wr   (i_vram_wr),
        .o_rgb       (o_rgb)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;    // 8 ns
    end

    // ======================================================================
    // compare tasks and run end
    // ======================================================================
    task automatic compare_rgb(input string name, input rgb_out_t got, input rgb_out_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            check_errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic note_timeout(input string what);
        timeout_errors++;
        $display("timeout: %s did not arrive in time", what);
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic int popcount8(input logic [7:0] value);
        int n;
        int k;
        n = 0;
        for (k = 0; k < 8; k++) begin
            n += value[k];
        end
        return n;
    endfunction

    // lit raster pixels for one {r,g,b} with each bitmap dot covering 2x2
    function automatic int expected_lit(input logic [2:0] rgb);
        int         total;
        int         c;
        int         r;
        vram_word_t w;
        total = 0;
        for (c = 0; c < COLS_VISIBLE; c++) begin
            for (r = 0; r < LINES_MAX; r++) begin
                w = model[{VCOL_W'(VRAM_COL_BASE + c), ROW_W'(r)}];
                if ((w.colour ^ 3'b111) == rgb) begin    // colour shows inverted
                    total += popcount8(w.pixels);
                end
            end
        end
        return total * H_SCALE * V_SCALE;
    endfunction

    // ======================================================================
    // vram writes
    // ======================================================================
    task automatic write_word(input logic [VADDR_W-1:0] addr, input vram_word_t word);
        @(posedge clk_pixel);
        #1;
        i_vram_wr.en   = 1'b1;
        i_vram_wr.addr = addr;
        i_vram_wr.data = word;
        model[addr] = word;
    endtask

    task automatic write_idle();
        @(posedge clk_pixel);
        #1;
        i_vram_wr.en = 1'b0;
    endtask

    task automatic fill_vram();
        int         c;
        int         r;
        vram_word_t w;
        for (c = VRAM_COL_BASE; c < VRAM_COL_BASE + COLS_VISIBLE; c++) begin
            for (r = 0; r < LINES_MAX; r++) begin
                w = VDATA_W'($urandom);
                write_word({VCOL_W'(c), ROW_W'(r)}, w);
            end
        end
        write_idle();
    endtask

    // about one write in four goes to a hidden column
    task automatic rewrite_during_blank();
        int         i;
        int         c;
        int         r;
        vram_word_t w;
        for (i = 0; i < 128; i++) begin
            if ($urandom % 4 == 0) begin
                c = $urandom % VRAM_COL_BASE;
            end else begin
                c = VRAM_COL_BASE + $urandom % COLS_VISIBLE;
            end
            r = $urandom % LINES_MAX;
            w = VDATA_W'($urandom);
            write_word({VCOL_W'(c), ROW_W'(r)}, w);
        end
        write_idle();
    endtask

    // ======================================================================
    // frame watching on the falling edge
    // ======================================================================
    task automatic wait_vblank(output bit ok);
        int gap;
        int n;
        gap = 0;
        n   = 0;
        while (gap <= H_TOTAL && n < 2 * H_TOTAL * V_TOTAL) begin
            @(negedge clk_pixel);
            n++;
            if (o_rgb.de) gap = 0;
            else gap++;                          // longer than a line = vblank
        end
        ok = (gap > H_TOTAL);
        if (!ok) note_timeout("vertical blanking");
    endtask

    task automatic wait_frame_start(output bit ok);
        int n;
        n = 0;
        while (!o_rgb.de && n < 2 * H_TOTAL * V_TOTAL) begin
            @(negedge clk_pixel);
            n++;
        end
        ok = o_rgb.de;
        if (!ok) note_timeout("first active line");
    endtask

    // runs from the first de sample until de stays low past a line
    task automatic collect_frame(output bit ok);
        int       gap;
        int       run;
        int       n;
        int       t;
        rgb_out_t exp_px;
        line_count   = 0;
        border_count = 0;
        dark_count   = 0;
        blank_bad    = 0;
        for (t = 1; t < 8; t++) begin
            lit_count[t] = 0;
        end
        gap = 0;
        run = 0;
        n   = 0;
        while (gap <= H_TOTAL && n < 2 * H_TOTAL * V_TOTAL) begin
            if (o_rgb.de) begin
                run++;
                gap = 0;
                if ({o_rgb.r, o_rgb.g, o_rgb.b} == 3'b000) begin
                    if (o_rgb.p) border_count++;
                    else dark_count++;           // clear dot or black colour
                end else begin
                    lit_count[{o_rgb.r, o_rgb.g, o_rgb.b}]++;
                    exp_px   = o_rgb;
                    exp_px.p = o_rgb.b;          // p tracks blue inside the window
                    compare_rgb("o_rgb lit pixel", o_rgb, exp_px);
                end
            end else begin
                if (run != 0) begin
                    line_count++;
                    compare_count("de cycles in line", run, H_ACTIVE);
                end
                run = 0;
                gap++;
                if (o_rgb != '0) blank_bad++;
            end
            @(negedge clk_pixel);
            n++;
        end
        ok = (gap > H_TOTAL);
        if (!ok) note_timeout("end of frame");
    endtask

    task automatic check_frame();
        int t;
        int exp_lit;
        int lit_sum;
        int window_area;
        window_area = PIXEL_MAX * H_SCALE * LINES_MAX * V_SCALE;
        lit_sum     = 0;
        compare_count("de lines per frame", line_count, V_ACTIVE);
        compare_count("border pixels", border_count, H_ACTIVE * V_ACTIVE - window_area);
        for (t = 1; t < 8; t++) begin
            exp_lit = expected_lit(3'(t));
            lit_sum += exp_lit;
            compare_count($sformatf("lit pixels rgb=%0d", t), lit_count[t], exp_lit);
        end
        compare_count("dark window pixels", dark_count, window_area - lit_sum);
        compare_count("lit pixels outside de", blank_bad, 0);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        int i;
        bit ok;
        i_reset        = 1'b1;
        i_vram_wr      = '0;
        check_errors   = 0;
        timeout_errors = 0;
        ok             = 1'b1;
        for (i = 0; i < VRAM_DEPTH; i++) begin
            model[i] = '0;
        end
        void'($urandom(32'h625829f0));

        for (i = 0; i < 16; i++) begin
            @(negedge clk_pixel);
            compare_rgb("o_rgb in reset", o_rgb, '0);
            @(posedge clk_pixel);
        end
        #1;
        i_reset = 1'b0;
        @(posedge clk_pixel);                    // first edge out of reset
        @(negedge clk_pixel);
        compare_rgb("o_rgb after reset", o_rgb, '0);

        fill_vram();
        wait_vblank(ok);                         // skip the frame under way
        if (ok) wait_frame_start(ok);
        if (ok) collect_frame(ok);
        if (ok) check_frame();

        if (ok) rewrite_during_blank();          // still inside vblank here
        if (ok) wait_frame_start(ok);
        if (ok) collect_frame(ok);
        if (ok) check_frame();

        finish_run();
    end

endmodule

// File: verilog/spec_video.sv
// video path top level: raster timer, screen scaler, video ram and pixel shifter
`timescale 1ns/100ps

module spec_video (
    input  logic                     i_clk_pixel,
    input  logic                     i_reset,
    input  spec_video_pkg::vram_wr_t i_vram_wr,
    output spec_video_pkg::rgb_out_t o_rgb
);
    import spec_video_pkg::*;

    raster_pos_t        pos;          // raster position
    logic               de;           // display enable, one clock behind pos
    bitmap_pos_t        bitmap;       // column, row, window
    logic [VADDR_W-1:0] vram_addr;    // display read address
    vram_word_t         vram_data;    // word for last clock's address

    // ======================================================================
    // raster and scaling
    // ======================================================================
    raster_timer u_raster_timer (
        .i_clk_pixel (i_clk_pixel),
        .i_reset     (i_reset),
        .o_pos       (pos),
        .o_de        (de)
    );

    screen_scaler u_screen_scaler (
        .i_clk_pixel (i_clk_pixel),
        .i_reset     (i_reset),
        .i_pos       (pos),
        .o_bitmap    (bitmap),
        .o_vram_addr (vram_addr)
    );

    // ======================================================================
    // memory and pixel out
    // ======================================================================
    video_ram u_video_ram (
        .i_clk_pixel (i_clk_pixel),
        .i_wr        (i_vram_wr),      // outside writes stand in for the cpu
        .i_rd_addr   (vram_addr),
        .o_rd_data   (vram_data)
    );

    pixel_shifter u_pixel_shifter (
        .i_clk_pixel (i_clk_pixel),
        .i_reset     (i_reset),
        .i_bitmap    (bitmap),
        .i_de        (de),
        .i_rd_data   (vram_data),
        .o_rgb       (o_rgb)
    );

endmodule

// File: video/pixel_shifter.sv
// byte fetch, dot select, border and blanking rules and the registered colour output
`timescale 1ns/100ps

module pixel_shifter (
    input  logic                        i_clk_pixel,
    input  logic                        i_reset,
    input  spec_video_pkg::bitmap_pos_t i_bitmap,
    input  logic                        i_de,
    input  spec_video_pkg::vram_word_t  i_rd_data,
    output spec_video_pkg::rgb_out_t    o_rgb
);
    import spec_video_pkg::*;

    logic [COL_W-1:0] col_d;         // column one clock back
    logic             phase_last;    // last raster pixel of the current bit phase
    logic [7:0]       fetch_byte;
    logic [2:0]       fetch_colour;
    logic [7:0]       shift_byte;    // byte on screen now
    logic [2:0]       shift_colour;  // inverted port C bits {7, 6, 4}
    logic             window_d;      // window flag aligned to byte groups
    logic             dot;

    // column unchanged since last clock, so this is the 2nd of H_SCALE pixels
    assign phase_last = (i_bitmap.col == col_d);

    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            col_d <= '0;
        end else begin
            col_d <= i_bitmap.col;
        end
    end

    // ======================================================================
    // fetch and shift stages
    // ======================================================================
    always_ff @(posedge i_clk_pixel) begin
        if (phase_last && i_bitmap.col[2:0] == 3'd4) begin
            fetch_byte   <= i_rd_data.pixels;     // ram answered the phase-4 address
            fetch_colour <= ~i_rd_data.colour;
        end
        if (phase_last && i_bitmap.col[2:0] == 3'd7) begin
            shift_byte   <= fetch_byte;           // shown during the next byte group
            shift_colour <= fetch_colour;
        end
    end

    // window sampled with the byte move, so it opens and closes on whole bytes
    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            window_d <= 1'b0;
        end else if (phase_last && i_bitmap.col[2:0] == 3'd7) begin
            window_d <= i_bitmap.window;
        end
    end

    assign dot = shift_byte[3'd7 - i_bitmap.col[2:0]];    // msb first

    // ======================================================================
    // colour output
    // ======================================================================
    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            o_rgb <= '0;
        end else if (!i_de) begin
            o_rgb <= '0;                                   // blanking
        end else if (window_d) begin
            o_rgb <= '{r:  dot & shift_colour[2],
                       g:  dot & shift_colour[1],
                       b:  dot & shift_colour[0],
                       p:  dot & shift_colour[0],          // p follows blue
                       de: 1'b1};
        end else begin
            o_rgb <= '{r: 1'b0, g: 1'b0, b: 1'b0, p: 1'b1, de: 1'b1};   // border
        end
    end

    // the byte-aligned window lies wholly inside the display area
    a_window_in_de: assert property (@(posedge i_clk_pixel) disable iff (i_reset)
        window_d |-> i_de)
        else $error("bitmap window open outside display enable");

endmodule

// File: video/video_ram.sv
// video ram: 16K x 11 dual-port memory, write port and registered read port
`timescale 1ns/100ps

module video_ram (
    input  logic                               i_clk_pixel,
    input  spec_video_pkg::vram_wr_t           i_wr,
    input  logic [spec_video_pkg::VADDR_W-1:0] i_rd_addr,
    output spec_video_pkg::vram_word_t         o_rd_data
);
    import spec_video_pkg::*;

    // 8 pixel bits + 3 colour bits per byte
    logic [VDATA_W-1:0] mem [0:VRAM_DEPTH-1];

    // ======================================================================
    // write side, plain strobe
    // ======================================================================
    always_ff @(posedge i_clk_pixel) begin
        if (i_wr.en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // ======================================================================
    // display side
    // ======================================================================
    // one clock latency, a same-address write returns the old word
    always_ff @(posedge i_clk_pixel) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// File: video/screen_scaler.sv
// scale and border counters, bitmap column and row, window flag and vram read address
`timescale 1ns/100ps

module screen_scaler (
    input  logic                                 i_clk_pixel,
    input  logic                                 i_reset,
    input  spec_video_pkg::raster_pos_t          i_pos,
    output spec_video_pkg::bitmap_pos_t          o_bitmap,
    output logic [spec_video_pkg::VADDR_W-1:0]   o_vram_addr
);
    import spec_video_pkg::*;

    logic line_end;
    logic frame_end;

    logic [$clog2(H_SCALE)-1:0]    hscale;      // raster pixel within a bitmap pixel
    logic [$clog2(V_SCALE)-1:0]    vscale;      // raster line within a bitmap row
    logic [$clog2(H_OFFSET+1)-1:0] hoffset;     // left border counter
    logic [$clog2(V_OFFSET+1)-1:0] voffset;     // top border counter
    logic                          left_border;
    logic                          top_border;
    logic [COL_W-1:0]              col;
    logic [ROW_W-1:0]              row;
    logic                          window;

    assign line_end  = (i_pos.h == POS_W'(H_TOTAL - 1));
    assign frame_end = line_end && (i_pos.v == POS_W'(V_TOTAL - 1));

    // ======================================================================
    // horizontal border offset then one column step per H_SCALE pixels
    // ======================================================================
    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            hscale      <= '0;
            hoffset     <= '0;
            col         <= '0;
            left_border <= 1'b1;
        end else if (line_end) begin
            hscale      <= '0;    // restart everything at line wrap
            hoffset     <= '0;
            col         <= '0;
            left_border <= 1'b1;
        end else begin
            if (hscale == H_SCALE - 1) begin
                hscale <= '0;
                if (!left_border && col < COL_LAST) begin
                    col <= col + 1'b1;    // holds at COL_LAST till line end
                end
            end else begin
                hscale <= hscale + 1'b1;
            end

            if (hoffset < H_OFFSET) begin
                hoffset <= hoffset + 1'b1;
            end else begin
                left_border <= 1'b0;
            end
        end
    end

    // ======================================================================
    // vertical counters stepped once per line
    // ======================================================================
    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            vscale     <= '0;
            voffset    <= '0;
            row        <= '0;
            top_border <= 1'b1;
        end else if (frame_end) begin
            vscale     <= '0;     // frame wrap
            voffset    <= '0;
            row        <= '0;
            top_border <= 1'b1;
        end else if (line_end) begin
            if (vscale == V_SCALE - 1) begin
                vscale <= '0;
                if (!top_border && row < LINES_MAX - 1) begin
                    row <= row + 1'b1;
                end
            end else begin
                vscale <= vscale + 1'b1;
            end

            if (voffset < V_OFFSET) begin
                voffset <= voffset + 1'b1;
            end else begin
                top_border <= 1'b0;
            end
        end
    end

    // coarse window rectangle that the shifter aligns to byte groups
    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            window <= 1'b0;
        end else begin
            window <= (i_pos.h >= H_OFFSET) && (i_pos.h < H_OFFSET + PIXEL_MAX * H_SCALE)
                   && (i_pos.v >= V_OFFSET) && (i_pos.v < V_OFFSET + LINES_MAX * V_SCALE);
        end
    end

    assign o_bitmap    = '{col: col, row: row, window: window};
    assign o_vram_addr = {VCOL_W'(VRAM_COL_BASE) + col[COL_W-1:3], row};    // {column, row}

    // row moves only at a line wrap and then by one or back to zero
    a_row_step: assert property (@(posedge i_clk_pixel) disable iff (i_reset)
        (row != $past(row)) |-> ($past(i_pos.h) == H_TOTAL - 1)
                                && ((row == $past(row) + 1'b1) || (row == '0)))
        else $error("bitmap row stepped badly, row=%0d", row);

endmodule

// File: verilog/raster_timer.sv
// raster timer: wrapping horizontal and vertical counters and display enable
`timescale 1ns/100ps

module raster_timer (
    input  logic                        i_clk_pixel,
    input  logic                        i_reset,
    output spec_video_pkg::raster_pos_t o_pos,
    output logic                        o_de
);
    import spec_video_pkg::*;

    logic h_last;    // last pixel of the line
    logic v_last;    // last line of the frame

    assign h_last = (o_pos.h == POS_W'(H_TOTAL - 1));
    assign v_last = (o_pos.v == POS_W'(V_TOTAL - 1));

    // ======================================================================
    // position counters
    // ======================================================================
    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            o_pos <= '0;
        end else begin
            if (h_last) begin
                o_pos.h <= '0;                 // new line
                if (v_last) begin
                    o_pos.v <= '0;             // new frame
                end else begin
                    o_pos.v <= o_pos.v + 1'b1;
                end
            end else begin
                o_pos.h <= o_pos.h + 1'b1;
            end
        end
    end

    // de lags the position by one clock
    always_ff @(posedge i_clk_pixel or posedge i_reset) begin
        if (i_reset) begin
            o_de <= 1'b0;
        end else begin
            o_de <= (o_pos.h < H_ACTIVE) && (o_pos.v < V_ACTIVE);
        end
    end

    // counters wrap at the totals, never beyond
    a_pos_range: assert property (@(posedge i_clk_pixel) disable iff (i_reset)
        (o_pos.h < H_TOTAL) && (o_pos.v < V_TOTAL))
        else $error("raster position out of range h=%0d v=%0d", o_pos.h, o_pos.v);

endmodule

// File: common/spec_video_pkg.sv
// raster, window and width constants plus the packed types of the video path
package spec_video_pkg;

    // ======================================================================
    // raster, 1280x720 at 50 Hz
    // ======================================================================
    localparam int H_TOTAL  = 1980;    // pixels per line incl. blanking
    localparam int V_TOTAL  = 750;     // lines per frame incl. blanking
    localparam int H_ACTIVE = 1280;
    localparam int V_ACTIVE = 720;

    // ======================================================================
    // bitmap window
    // ======================================================================
    localparam int H_SCALE   = 2;      // raster pixels per bitmap pixel
    localparam int V_SCALE   = 2;      // raster lines per bitmap row
    localparam int H_OFFSET  = 248;    // left border width
    localparam int V_OFFSET  = 104;    // top border height
    localparam int PIXEL_MAX = 384;
    localparam int LINES_MAX = 256;

    localparam int VRAM_COL_BASE = 16; // vram column of byte column 0
    localparam int COLS_VISIBLE  = 48; // PIXEL_MAX / 8

    // column counter runs one byte group past the bitmap,
    // the fetch stage leads the display by one byte
    localparam int COL_LAST = COLS_VISIBLE * 8 + 7;

    // ======================================================================
    // widths
    // ======================================================================
    localparam int POS_W      = 12;
    localparam int VADDR_W    = 14;
    localparam int VDATA_W    = 11;
    localparam int COL_W      = 9;                  // holds 0..COL_LAST
    localparam int ROW_W      = 8;                  // holds 0..LINES_MAX-1
    localparam int VCOL_W     = VADDR_W - ROW_W;    // vram column field
    localparam int VRAM_DEPTH = 1 << VADDR_W;

    // raster coordinate pair
    typedef struct packed {
        logic [POS_W-1:0] h;
        logic [POS_W-1:0] v;
    } raster_pos_t;

    // one vram word: colour sits above the pixel byte
    typedef struct packed {
        logic [2:0] colour;    // port C bits 7, 6, 4
        logic [7:0] pixels;    // msb is the leftmost dot
    } vram_word_t;

    // write strobe from outside, no handshake
    typedef struct packed {
        logic               en;
        logic [VADDR_W-1:0] addr;    // {column, row}
        vram_word_t         data;
    } vram_wr_t;

    typedef struct packed {
        logic [COL_W-1:0] col;       // bitmap pixel, [2:0] is the bit phase
        logic [ROW_W-1:0] row;
        logic             window;    // raster inside the bitmap rectangle
    } bitmap_pos_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
        logic p;     // extra blue level, also lights the border
        logic de;
    } rgb_out_t;

endpackage
